// File: tb.f
common/ahb_pkg.sv
hw/ahb_decoder.sv
ram/ahb_ram.sv
gpio/ahb_gpio.sv
hw/trst_pulse.sv
hw/ahb_system.sv
bench/ahb_props.sv
bench/ahb_checker.sv
bench/tb_ahb_system.sv

// File: run.sh
#!/bin/sh
# build and run the AHB system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ahb_system \
    -Mdir obj_dir -f tb.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_ahb_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

// File: bench/tb_ahb_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_system;
    import ahb_pkg::*;

    // RAM fill, about 300 transfers and the GPIO settle waits, with margin
    localparam int max_cycles = 2000;
    localparam addr_t gpio_base = {region_gpio, 28'h0};
    localparam ahb_req_t idle_req = '{haddr: '0, hwrite: 1'b0, hsize: size_word, htrans: idle};

    logic                hclk = 1'b0;
    logic                arst_n;
    ahb_req_t            req;
    data_t               hwdata;
    data_t               hrdata;
    logic [red_w-1:0]    switches;
    logic [button_w-1:0] buttons;
    logic [red_w-1:0]    red_leds;
    logic [green_w-1:0]  green_leds;
    logic                trst_probe_n;
    logic                trst_n;
    logic [15:0]         lfsr = 16'd4360;
    int                  cycles = 0;
    int                  error_count;

    ahb_system uut (.*);

    ahb_checker chk (.*);

    always #4 hclk = ~hclk;

    always @(posedge hclk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output data_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic ahb_req_t make_req(input addr_t addr, input logic wr, input size_t size);
        ahb_req_t r;
        r.haddr  = addr;
        r.hwrite = wr;
        r.hsize  = size;
        r.htrans = nonseq;
        return r;
    endfunction

    function automatic data_t fill_value(input addr_t addr);
        return {addr[15:0] ^ 16'hA5C3, ~addr[15:0]};
    endfunction

    task automatic drive_cycle(input ahb_req_t r, input data_t wd);
        @(negedge hclk);
        req    = r;
        hwdata = wd;
    endtask

    task automatic bus_write(input addr_t addr, input size_t size, input data_t wd);
        drive_cycle(make_req(addr, 1'b1, size), '0);
        drive_cycle(idle_req, wd);
    endtask

    task automatic bus_read(input addr_t addr);
        drive_cycle(make_req(addr, 1'b0, size_word), '0);
        drive_cycle(idle_req, '0);
    endtask

    // read address phase overlaps the write data phase
    task automatic write_then_read(input addr_t waddr, input size_t wsize, input data_t wd,
                                   input addr_t raddr);
        drive_cycle(make_req(waddr, 1'b1, wsize), '0);
        drive_cycle(make_req(raddr, 1'b0, size_word), wd);
        drive_cycle(idle_req, '0);
    endtask

    // back-to-back word writes over the whole RAM
    task automatic fill_ram();
        data_t prev;
        prev = '0;
        for (int i = 0; i < ram_words; i++) begin
            drive_cycle(make_req(addr_t'(i) << 2, 1'b1, size_word), prev);
            prev = fill_value(addr_t'(i) << 2);
        end
        drive_cycle(idle_req, prev);
    endtask

    initial begin
        data_t a;
        data_t b;
        data_t d;
        arst_n       = 1'b0;
        req          = idle_req;
        hwdata       = '0;
        switches     = '0;
        buttons      = '0;
        trst_probe_n = 1'b1;
        repeat (4) @(negedge hclk);
        arst_n = 1'b1;

        chk.test_name = "ram_fill";
        fill_ram();
        chk.test_name = "ram_word";
        repeat (48) begin
            random_bits(8, a);
            random_bits(32, d);
            bus_write(a << 2, size_word, d);
            random_bits(8, b);
            bus_read(b << 2);
        end
        chk.test_name = "ram_lanes";
        repeat (16) begin
            random_bits(10, a);
            random_bits(1, b);
            random_bits(32, d);
            bus_write(b[0] ? (a & ~32'd1) : a, b[0] ? size_half : size_byte, d);
            bus_read(a & ~32'd3);
        end
        chk.test_name = "ram_forward";
        repeat (12) begin
            random_bits(10, a);
            random_bits(1, b);
            random_bits(32, d);
            write_then_read(b[0] ? (a & ~32'd3) : a, b[0] ? size_word : size_byte, d,
                            a & ~32'd3);
        end
        chk.test_name = "ram_other_word";
        repeat (8) begin
            random_bits(8, a);
            random_bits(32, d);
            write_then_read(a << 2, size_word, d, ((a + 1) & 32'hff) << 2);
        end

        chk.test_name = "gpio_leds";
        repeat (6) begin
            random_bits(32, d);
            bus_write(gpio_base + 32'(gpio_red), size_word, d);
            bus_read(gpio_base + 32'(gpio_red));
            random_bits(32, d);
            bus_write(gpio_base + 32'(gpio_green), size_word, d);
            bus_read(gpio_base + 32'(gpio_green));
        end
        chk.test_name = "gpio_inputs";
        repeat (6) begin
            random_bits(red_w, a);
            random_bits(button_w, b);
            @(negedge hclk);
            switches = a[red_w-1:0];
            buttons  = b[button_w-1:0];
            repeat (4) @(negedge hclk);
            bus_read(gpio_base + 32'(gpio_switch));
            bus_read(gpio_base + 32'(gpio_button));
        end
        chk.test_name = "unmapped";
        random_bits(32, d);
        bus_write(32'h2000_0010, size_word, d);
        bus_read(32'h2000_0010);
        bus_read(32'hF000_0000);
        bus_read(gpio_base);
        bus_read(32'h0000_0010);

        // probe reset toggled after the power-up pulse
        chk.test_name = "trst";
        repeat (8) begin
            random_bits(1, b);
            random_bits(2, a);
            @(negedge hclk);
            trst_probe_n = b[0];
            repeat (a + 1) @(negedge hclk);
        end
        trst_probe_n = 1'b1;
        repeat (3) @(negedge hclk);

        chk.print_counts();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/ahb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_checker (
    input  logic                         hclk,
    input  logic                         arst_n,
    input  ahb_pkg::ahb_req_t            req,
    input  ahb_pkg::data_t               hwdata,
    input  ahb_pkg::data_t               hrdata,
    input  logic [ahb_pkg::red_w-1:0]    switches,
    input  logic [ahb_pkg::button_w-1:0] buttons,
    input  logic [ahb_pkg::red_w-1:0]    red_leds,
    input  logic [ahb_pkg::green_w-1:0]  green_leds,
    input  logic                         trst_probe_n,
    input  logic                         trst_n,
    output int                           error_count
);
    import ahb_pkg::*;

    string              test_name = "reset";
    data_t              shadow_ram [ram_words];
    logic [red_w-1:0]   shadow_red;
    logic [green_w-1:0] shadow_green;
    ahb_req_t           dp_req;
    logic               dp_valid;
    int                 edges;
    int                 data_errors = 0;
    int                 pin_errors = 0;

    assign error_count = data_errors + pin_errors;

    // expected read data from the memory map
    function automatic data_t expected_rdata(input addr_t addr);
        data_t res;
        res = '0;
        if (addr[31:28] == region_ram) begin
            res = shadow_ram[addr[ram_aw+1:2]];
        end else if (addr[31:28] == region_gpio) begin
            case (addr[3:0])
                gpio_red:    res = data_t'(shadow_red);
                gpio_green:  res = data_t'(shadow_green);
                gpio_switch: res = data_t'(switches);
                gpio_button: res = data_t'(buttons);
                default:     res = '0;
            endcase
        end
        return res;
    endfunction

    task automatic apply_write(input ahb_req_t r, input data_t wd);
        logic [3:0] mask;
        case (r.hsize)
            size_byte: mask = 4'b0001 << r.haddr[1:0];
            size_half: mask = r.haddr[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
        if (r.haddr[31:28] == region_ram) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    shadow_ram[r.haddr[ram_aw+1:2]][8*i +: 8] = wd[8*i +: 8];
                end
            end
        end else if (r.haddr[31:28] == region_gpio) begin
            if (r.haddr[3:0] == gpio_red) begin
                shadow_red = wd[red_w-1:0];
            end
            if (r.haddr[3:0] == gpio_green) begin
                shadow_green = wd[green_w-1:0];
            end
        end
    endtask

    task automatic compare(input string what, input data_t exp, input data_t act,
                           input logic is_pin);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h on %s", test_name, exp, act, what);
            if (is_pin) begin
                pin_errors++;
            end else begin
                data_errors++;
            end
        end
    endtask

    // sampled at the rising edge, before the DUT registers move
    always @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            dp_valid     = 1'b0;
            shadow_red   = '0;
            shadow_green = '0;
            edges        = 0;
        end else begin
            compare("red_leds", data_t'(shadow_red), data_t'(red_leds), 1'b1);
            compare("green_leds", data_t'(shadow_green), data_t'(green_leds), 1'b1);
            // low for the pulse, then the probe reset passes through
            compare("trst_n", data_t'((edges >= trst_cycles) && trst_probe_n), data_t'(trst_n),
                    1'b1);
            if (!dp_valid) begin
                compare("idle hrdata", '0, hrdata, 1'b0);
            end else if (!dp_req.hwrite) begin
                compare("hrdata", expected_rdata(dp_req.haddr), hrdata, 1'b0);
            end else begin
                apply_write(dp_req, hwdata);
            end
            dp_valid = (req.htrans == nonseq) || (req.htrans == seq);
            dp_req   = req;
            if (edges < trst_cycles) begin
                edges++;
            end
        end
    end

    task print_counts();
        $display("errors: data %0d, pins %0d, total %0d", data_errors, pin_errors, error_count);
    endtask

endmodule

`default_nettype wire

// File: bench/ahb_props.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_props (
    input logic              hclk,
    input logic              arst_n,
    input ahb_pkg::ahb_req_t req,
    input logic              trst_probe_n,
    input logic              trst_n
);
    import ahb_pkg::*;

    int edges;

    // counts rising edges since reset up to the pulse length
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            edges <= 0;
        end else if (edges < trst_cycles) begin
            edges <= edges + 1;
        end
    end

    htrans_known: assert property (@(posedge hclk) disable iff (!arst_n)
        !$isunknown(req.htrans))
        else $error("htrans is unknown after reset");

    trst_held_low: assert property (@(posedge hclk) disable iff (!arst_n)
        (edges < trst_cycles) |-> !trst_n)
        else $error("trst_n released before the power-up pulse ended");

    trst_follows_probe: assert property (@(posedge hclk) disable iff (!arst_n)
        (edges >= trst_cycles) |-> (trst_n == trst_probe_n))
        else $error("trst_n does not follow the probe reset after the power-up pulse");

endmodule

bind ahb_system ahb_props props (
    .hclk         ( hclk         ),
    .arst_n       ( arst_n       ),
    .req          ( req          ),
    .trst_probe_n ( trst_probe_n ),
    .trst_n       ( trst_n       )
);

`default_nettype wire

// File: hw/ahb_system.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_system (
    input  logic                         hclk,
    input  logic                         arst_n,
    input  ahb_pkg::ahb_req_t            req,
    input  ahb_pkg::data_t               hwdata,
    output ahb_pkg::data_t               hrdata,
    input  logic [ahb_pkg::red_w-1:0]    switches,
    input  logic [ahb_pkg::button_w-1:0] buttons,
    output logic [ahb_pkg::red_w-1:0]    red_leds,
    output logic [ahb_pkg::green_w-1:0]  green_leds,
    input  logic                         trst_probe_n,
    output logic                         trst_n
);
    import ahb_pkg::*;

    logic  ram_sel;
    logic  gpio_sel;
    data_t ram_rdata;
    data_t gpio_rdata;

    ahb_decoder decoder (
        .hclk       ( hclk       ),
        .arst_n     ( arst_n     ),
        .req        ( req        ),
        .ram_rdata  ( ram_rdata  ),
        .gpio_rdata ( gpio_rdata ),
        .ram_sel    ( ram_sel    ),
        .gpio_sel   ( gpio_sel   ),
        .hrdata     ( hrdata     )
    );

    ahb_ram ram (
        .hclk   ( hclk      ),
        .arst_n ( arst_n    ),
        .sel    ( ram_sel   ),
        .req    ( req       ),
        .hwdata ( hwdata    ),
        .rdata  ( ram_rdata )
    );

    ahb_gpio gpio (
        .hclk       ( hclk       ),
        .arst_n     ( arst_n     ),
        .sel        ( gpio_sel   ),
        .req        ( req        ),
        .hwdata     ( hwdata     ),
        .rdata      ( gpio_rdata ),
        .switches   ( switches   ),
        .buttons    ( buttons    ),
        .red_leds   ( red_leds   ),
        .green_leds ( green_leds )
    );

    // holds the debug reset low right after power-up
    trst_pulse trst_gen (
        .hclk         ( hclk         ),
        .arst_n       ( arst_n       ),
        .trst_probe_n ( trst_probe_n ),
        .trst_n       ( trst_n       )
    );

endmodule

`default_nettype wire

// File: hw/trst_pulse.sv
`timescale 1ns/1ns
`default_nettype none

module trst_pulse (
    input  logic hclk,
    input  logic arst_n,
    input  logic trst_probe_n,
    output logic trst_n
);
    import ahb_pkg::*;

    trst_cnt_t cnt;
    logic      trst_q;

    // counts up once and then sits at the top
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            trst_q <= 1'b0;
        end else begin
            if (cnt != trst_cnt_t'(trst_cycles - 1)) begin
                cnt <= cnt + 1'b1;
            end
            // released on the trst_cycles-th edge
            trst_q <= trst_q || (cnt == trst_cnt_t'(trst_cycles - 1));
        end
    end

    // either source can hold the debug logic in reset
    assign trst_n = trst_q & trst_probe_n;

endmodule

`default_nettype wire

// File: gpio/ahb_gpio.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_gpio (
    input  logic                         hclk,
    input  logic                         arst_n,
    input  logic                         sel,
    input  ahb_pkg::ahb_req_t            req,
    input  ahb_pkg::data_t               hwdata,
    output ahb_pkg::data_t               rdata,
    input  logic [ahb_pkg::red_w-1:0]    switches,
    input  logic [ahb_pkg::button_w-1:0] buttons,
    output logic [ahb_pkg::red_w-1:0]    red_leds,
    output logic [ahb_pkg::green_w-1:0]  green_leds
);
    import ahb_pkg::*;

    logic                wr_q;
    gpio_off_t           off_q;
    logic [red_w-1:0]    sw_meta;
    logic [red_w-1:0]    sw_sync;
    logic [button_w-1:0] btn_meta;
    logic [button_w-1:0] btn_sync;

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= sel && req.hwrite;
        end
    end

    // only the low nibble picks a register, the rest aliases
    always_ff @(posedge hclk) begin
        if (sel) begin
            off_q <= req.haddr[3:0];
        end
    end

    // LED registers, upper data bits are dropped
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (wr_q) begin
            if (off_q == gpio_red) begin
                red_leds <= hwdata[red_w-1:0];
            end
            if (off_q == gpio_green) begin
                green_leds <= hwdata[green_w-1:0];
            end
        end
    end

    // two-flop synchronizers for the pins
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            sw_meta  <= '0;
            sw_sync  <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            sw_meta  <= switches;
            sw_sync  <= sw_meta;
            btn_meta <= buttons;
            btn_sync <= btn_meta;
        end
    end

    always_comb begin
        case (off_q)
            gpio_red:    rdata = data_t'(red_leds);
            gpio_green:  rdata = data_t'(green_leds);
            gpio_switch: rdata = data_t'(sw_sync);
            gpio_button: rdata = data_t'(btn_sync);
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: ram/ahb_ram.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_ram (
    input  logic              hclk,
    input  logic              arst_n,
    input  logic              sel,
    input  ahb_pkg::ahb_req_t req,
    input  ahb_pkg::data_t    hwdata,
    output ahb_pkg::data_t    rdata
);
    import ahb_pkg::*;

    data_t      mem [ram_words];
    word_idx_t  addr_idx;
    lane_mask_t addr_mask;
    logic       wr_q;
    word_idx_t  wr_idx_q;
    lane_mask_t wr_mask_q;
    data_t      fwd_data;
    data_t      rd_q;

    // word index, RAM aliases across its region
    assign addr_idx = req.haddr[ram_aw+1:2];

    // byte lanes, little endian
    always_comb begin
        case (req.hsize)
            size_byte: addr_mask = lane_mask_t'(4'b0001 << req.haddr[1:0]);
            size_half: addr_mask = req.haddr[1] ? 4'b1100 : 4'b0011;
            default:   addr_mask = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= sel && req.hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (sel) begin
            wr_idx_q  <= addr_idx;
            wr_mask_q <= addr_mask;
        end
    end

    // commit at the end of the write data phase
    always_ff @(posedge hclk) begin
        if (wr_q) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_mask_q[i]) begin
                    mem[wr_idx_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // pending write to the same word wins lane by lane
    always_comb begin
        fwd_data = mem[addr_idx];
        for (int i = 0; i < 4; i++) begin
            if (wr_q && (wr_idx_q == addr_idx) && wr_mask_q[i]) begin
                fwd_data[8*i +: 8] = hwdata[8*i +: 8];
            end
        end
    end

    // read launched in the address phase
    always_ff @(posedge hclk) begin
        if (sel && !req.hwrite) begin
            rd_q <= fwd_data;
        end
    end

    assign rdata = rd_q;

endmodule

`default_nettype wire

// File: hw/ahb_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module ahb_decoder (
    input  logic              hclk,
    input  logic              arst_n,
    input  ahb_pkg::ahb_req_t req,
    input  ahb_pkg::data_t    ram_rdata,
    input  ahb_pkg::data_t    gpio_rdata,
    output logic              ram_sel,
    output logic              gpio_sel,
    output ahb_pkg::data_t    hrdata
);
    import ahb_pkg::*;

    logic       active;
    region_t    region;
    slave_sel_t sel_q;

    // BUSY counts as IDLE, bursts are plain singles
    assign active = (req.htrans == nonseq) || (req.htrans == seq);
    assign region = req.haddr[31:28];

    assign ram_sel  = active && (region == region_ram);
    assign gpio_sel = active && (region == region_gpio);

    // remember who owns the next data phase
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= sel_none;
        end else if (ram_sel) begin
            sel_q <= sel_ram;
        end else if (gpio_sel) begin
            sel_q <= sel_gpio;
        end else begin
            sel_q <= sel_none;
        end
    end

    // unmapped or idle reads as zero
    always_comb begin
        case (sel_q)
            sel_ram:  hrdata = ram_rdata;
            sel_gpio: hrdata = gpio_rdata;
            default:  hrdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: common/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [2:0]  size_t;

    // AHB-Lite transfer type codes
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonseq = 2'b10,
        seq    = 2'b11
    } trans_t;

    // hsize codes the slaves understand
    localparam size_t size_byte = 3'b000;
    localparam size_t size_half = 3'b001;
    localparam size_t size_word = 3'b010;

    // address phase bundle from the master
    typedef struct packed {
        addr_t  haddr;
        logic   hwrite;
        size_t  hsize;
        trans_t htrans;
    } ahb_req_t;

    typedef enum logic [1:0] {
        sel_none = 2'b00,
        sel_ram  = 2'b01,
        sel_gpio = 2'b10
    } slave_sel_t;

    // memory map, top nibble of haddr
    typedef logic [3:0] region_t;
    localparam region_t region_ram  = 4'h0;
    localparam region_t region_gpio = 4'h1;

    localparam int ram_words = 256;
    localparam int ram_aw    = 8;
    typedef logic [ram_aw-1:0] word_idx_t;
    typedef logic [3:0]        lane_mask_t;

    // GPIO pins and register offsets
    localparam int red_w    = 18;
    localparam int green_w  = 9;
    localparam int button_w = 5;
    typedef logic [3:0] gpio_off_t;
    localparam gpio_off_t gpio_red    = 4'h0;
    localparam gpio_off_t gpio_green  = 4'h4;
    localparam gpio_off_t gpio_switch = 4'h8;
    localparam gpio_off_t gpio_button = 4'hC;

    // debug reset pulse length in cycles
    localparam int trst_cycles = 16;
    typedef logic [$clog2(trst_cycles)-1:0] trst_cnt_t;

endpackage

`default_nettype wire
